// File: hw/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
  input  op_e   op,
  input  word_t a,
  input  word_t b,
  input  word_t imm,
  input  word_t pc,
  output word_t result,
  output logic  take,
  output word_t target
);

  always_comb begin
    result = '0;
    take   = 1'b0;
    case (op)
      OP_LUI:   result = imm;
      // register-immediate group
      OP_ADDI:  result = a + imm;
      OP_SLTI:  result = {31'b0, $signed(a) < $signed(imm)};
      OP_SLTIU: result = {31'b0, a < imm};
      OP_XORI:  result = a ^ imm;
      OP_ORI:   result = a | imm;
      OP_ANDI:  result = a & imm;
      OP_SLLI:  result = a << imm[4:0];
      OP_SRLI:  result = a >> imm[4:0];
      OP_SRAI:  result = $signed(a) >>> imm[4:0];
      // register-register group
      OP_ADD:   result = a + b;
      OP_SUB:   result = a - b;
      OP_SLL:   result = a << b[4:0];
      OP_SLT:   result = {31'b0, $signed(a) < $signed(b)};
      OP_SLTU:  result = {31'b0, a < b};
      OP_XOR:   result = a ^ b;
      OP_SRL:   result = a >> b[4:0];
      OP_SRA:   result = $signed(a) >>> b[4:0];
      OP_OR:    result = a | b;
      OP_AND:   result = a & b;
      // branch conditions
      OP_BEQ:   take = a == b;
      OP_BNE:   take = a != b;
      OP_BLT:   take = $signed(a) < $signed(b);
      OP_BGE:   take = $signed(a) >= $signed(b);
      OP_BLTU:  take = a < b;
      OP_BGEU:  take = a >= b;
      // jumps always redirect and link pc + 4
      OP_JAL, OP_JALR: begin
        result = pc + 32'd4;
        take   = 1'b1;
      end
      default: result = '0;
    endcase
  end

  // jalr is register relative with bit 0 cleared, the rest are pc relative
  assign target = (op == OP_JALR) ? ((a + imm) & ~32'd1) : pc + imm;

endmodule

// File: hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  logic          redirect,
  input  word_t         f_pc,
  input  insn_t         insn_from_imem,
  input  logic          w_we,
  input  reg_idx_t      w_rd,
  input  word_t         w_data,
  output word_t         d_pc,
  output insn_t         d_insn,
  output cycle_status_e d_status,
  output op_e           d_op,
  output reg_idx_t      d_rs1,
  output reg_idx_t      d_rs2,
  output word_t         d_rs1_data,
  output word_t         d_rs2_data,
  output reg_idx_t      d_rd,
  output logic          d_we,
  output word_t         d_imm,
  output logic          d_halt
);

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  word_t      rf_rs1_data;
  word_t      rf_rs2_data;
  logic       writes;

  // a zero instruction word decodes as a nop, so bubbles write nothing
  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      d_pc     <= '0;
      d_insn   <= '0;
      d_status <= rst ? CYCLE_RESET : CYCLE_TAKEN_BRANCH;
    end else begin
      d_pc     <= f_pc;
      d_insn   <= insn_from_imem;
      d_status <= CYCLE_NO_STALL;
    end
  end

  assign opcode = d_insn[6:0];
  assign funct3 = d_insn[14:12];
  assign funct7 = d_insn[31:25];
  assign d_rd   = d_insn[11:7];
  assign d_rs1  = d_insn[19:15];
  assign d_rs2  = d_insn[24:20];

  // sign-extended immediates per format
  assign imm_i = {{20{d_insn[31]}}, d_insn[31:20]};
  assign imm_b = {{19{d_insn[31]}}, d_insn[31], d_insn[7], d_insn[30:25], d_insn[11:8], 1'b0};
  assign imm_j = {{11{d_insn[31]}}, d_insn[31], d_insn[19:12], d_insn[20], d_insn[30:21], 1'b0};
  assign imm_u = {d_insn[31:12], 12'b0};

  always_comb begin
    d_op  = OP_NOP;
    d_imm = imm_i;
    case (opcode)
      OPC_LUI: begin
        d_op  = OP_LUI;
        d_imm = imm_u;
      end
      OPC_JAL: begin
        d_op  = OP_JAL;
        d_imm = imm_j;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) d_op = OP_JALR;
      end
      OPC_BRANCH: begin
        d_imm = imm_b;
        case (funct3)
          3'b000:  d_op = OP_BEQ;
          3'b001:  d_op = OP_BNE;
          3'b100:  d_op = OP_BLT;
          3'b101:  d_op = OP_BGE;
          3'b110:  d_op = OP_BLTU;
          3'b111:  d_op = OP_BGEU;
          default: d_op = OP_NOP;
        endcase
      end
      OPC_REG_IMM: begin
        case (funct3)
          3'b000:  d_op = OP_ADDI;
          3'b010:  d_op = OP_SLTI;
          3'b011:  d_op = OP_SLTIU;
          3'b100:  d_op = OP_XORI;
          3'b110:  d_op = OP_ORI;
          3'b111:  d_op = OP_ANDI;
          3'b001:  d_op = (funct7 == F7_BASE) ? OP_SLLI : OP_NOP;
          default: begin
            // srli and srai share funct3 101
            if (funct7 == F7_BASE) d_op = OP_SRLI;
            else if (funct7 == F7_ALT) d_op = OP_SRAI;
          end
        endcase
      end
      OPC_REG_REG: begin
        if (funct7 == F7_BASE) begin
          case (funct3)
            3'b000:  d_op = OP_ADD;
            3'b001:  d_op = OP_SLL;
            3'b010:  d_op = OP_SLT;
            3'b011:  d_op = OP_SLTU;
            3'b100:  d_op = OP_XOR;
            3'b101:  d_op = OP_SRL;
            3'b110:  d_op = OP_OR;
            default: d_op = OP_AND;
          endcase
        end else if (funct7 == F7_ALT) begin
          if (funct3 == 3'b000) d_op = OP_SUB;
          else if (funct3 == 3'b101) d_op = OP_SRA;
        end
      end
      OPC_SYSTEM: begin
        if (d_insn[31:7] == '0) d_op = OP_ECALL;
      end
      default: d_op = OP_NOP;
    endcase
  end

  // x0 is dropped here so later stages never compare against it
  assign writes = !(d_op inside {OP_NOP, OP_ECALL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE,
                                 OP_BLTU, OP_BGEU});
  assign d_we   = writes && d_rd != '0;
  assign d_halt = d_op == OP_ECALL;

  reg_file i_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1      (d_rs1),
    .rs2      (d_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .we       (w_we),
    .rd       (w_rd),
    .wd       (w_data)
  );

  // wd bypass, the write lands in the file only at the end of this cycle
  assign d_rs1_data = (w_we && w_rd == d_rs1) ? w_data : rf_rs1_data;
  assign d_rs2_data = (w_we && w_rd == d_rs2) ? w_data : rf_rs2_data;

endmodule

// File: hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import rv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  word_t         d_pc,
  input  insn_t         d_insn,
  input  cycle_status_e d_status,
  input  op_e           d_op,
  input  reg_idx_t      d_rs1,
  input  reg_idx_t      d_rs2,
  input  word_t         d_rs1_data,
  input  word_t         d_rs2_data,
  input  reg_idx_t      d_rd,
  input  logic          d_we,
  input  word_t         d_imm,
  input  logic          d_halt,
  input  logic          m_we,
  input  reg_idx_t      m_rd,
  input  word_t         m_data,
  input  logic          w_we,
  input  reg_idx_t      w_rd,
  input  word_t         w_data,
  output word_t         x_pc,
  output insn_t         x_insn,
  output cycle_status_e x_status,
  output logic          x_we,
  output reg_idx_t      x_rd,
  output word_t         x_result,
  output logic          x_halt,
  output logic          redirect,
  output word_t         redirect_pc
);

  op_e      e_op;
  reg_idx_t e_rs1;
  reg_idx_t e_rs2;
  word_t    e_rs1_data;
  word_t    e_rs2_data;
  word_t    e_imm;
  word_t    op_a;
  word_t    op_b;

  // the instruction in decode is squashed along with the one in fetch
  always_ff @(posedge clk) begin
    if (rst || redirect) begin
      x_pc     <= '0;
      x_insn   <= '0;
      x_status <= rst ? CYCLE_RESET : CYCLE_TAKEN_BRANCH;
      x_we     <= 1'b0;
      x_rd     <= '0;
      x_halt   <= 1'b0;
      e_op     <= OP_NOP;
      e_rs1    <= '0;
      e_rs2    <= '0;
    end else begin
      x_pc     <= d_pc;
      x_insn   <= d_insn;
      x_status <= d_status;
      x_we     <= d_we;
      x_rd     <= d_rd;
      x_halt   <= d_halt;
      e_op     <= d_op;
      e_rs1    <= d_rs1;
      e_rs2    <= d_rs2;
    end
  end

  // operand payload
  always_ff @(posedge clk) begin
    e_rs1_data <= d_rs1_data;
    e_rs2_data <= d_rs2_data;
    e_imm      <= d_imm;
  end

  // mx has priority since it holds the younger result
  always_comb begin
    if (m_we && m_rd == e_rs1) begin
      op_a = m_data;
    end else if (w_we && w_rd == e_rs1) begin
      op_a = w_data;
    end else begin
      op_a = e_rs1_data;
    end
    if (m_we && m_rd == e_rs2) begin
      op_b = m_data;
    end else if (w_we && w_rd == e_rs2) begin
      op_b = w_data;
    end else begin
      op_b = e_rs2_data;
    end
  end

  alu i_alu (
    .op     (e_op),
    .a      (op_a),
    .b      (op_b),
    .imm    (e_imm),
    .pc     (x_pc),
    .result (x_result),
    .take   (redirect),
    .target (redirect_pc)
  );

  // bubbles never redirect
  assert property (@(posedge clk) disable iff (rst)
    redirect |-> x_status == CYCLE_NO_STALL);

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  redirect,
  input  word_t redirect_pc,
  output word_t pc
);

  word_t next_pc;

  // a redirect from execute overrides the sequential path
  assign next_pc = redirect ? redirect_pc : pc + 32'd4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

  // branch and jump targets from execute must keep the pc word aligned
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: hw/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rs1_data,
  output word_t    rs2_data,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    wd
);

  word_t regs [32];

  // combinational reads
  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      // entry 0 is cleared on reset and never written
      regs[rd] <= wd;
    end
  end

endmodule

// File: hw/retire_stage.sv
`timescale 1ns/1ps

module retire_stage import rv_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  word_t         x_pc,
  input  insn_t         x_insn,
  input  cycle_status_e x_status,
  input  logic          x_we,
  input  reg_idx_t      x_rd,
  input  word_t         x_result,
  input  logic          x_halt,
  output logic          m_we,
  output reg_idx_t      m_rd,
  output word_t         m_data,
  output logic          w_we,
  output reg_idx_t      w_rd,
  output word_t         w_data,
  output word_t         trace_pc,
  output insn_t         trace_insn,
  output cycle_status_e trace_status,
  output logic          halt
);

  word_t         m_pc;
  insn_t         m_insn;
  cycle_status_e m_status;
  logic          m_halt;

  // memory stage, a plain register with no data memory behind it
  always_ff @(posedge clk) begin
    if (rst) begin
      m_status <= CYCLE_RESET;
      m_we     <= 1'b0;
      m_halt   <= 1'b0;
    end else begin
      m_status <= x_status;
      m_we     <= x_we;
      m_halt   <= x_halt;
    end
    m_pc   <= x_pc;
    m_insn <= x_insn;
    m_rd   <= x_rd;
    m_data <= x_result;
  end

  // writeback stage, also the commit and trace point
  always_ff @(posedge clk) begin
    if (rst) begin
      trace_status <= CYCLE_RESET;
      w_we         <= 1'b0;
      halt         <= 1'b0;
    end else begin
      trace_status <= m_status;
      w_we         <= m_we;
      halt         <= m_halt;
    end
    trace_pc   <= m_pc;
    trace_insn <= m_insn;
    w_rd       <= m_rd;
    w_data     <= m_data;
  end

  assert property (@(posedge clk) disable iff (rst) trace_status != CYCLE_INVALID);

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; #(
  parameter word_t RESET_PC = 32'h0
) (
  input  logic          clk,
  input  logic          rst,
  output word_t         pc,
  input  insn_t         insn_from_imem,
  output logic          w_we,
  output reg_idx_t      w_rd,
  output word_t         w_data,
  output word_t         trace_pc,
  output insn_t         trace_insn,
  output cycle_status_e trace_status,
  output logic          halt
);

  word_t f_pc;

  // decode to execute
  word_t         d_pc;
  insn_t         d_insn;
  cycle_status_e d_status;
  op_e           d_op;
  reg_idx_t      d_rs1;
  reg_idx_t      d_rs2;
  word_t         d_rs1_data;
  word_t         d_rs2_data;
  reg_idx_t      d_rd;
  logic          d_we;
  word_t         d_imm;
  logic          d_halt;

  // execute to retire
  word_t         x_pc;
  insn_t         x_insn;
  cycle_status_e x_status;
  logic          x_we;
  reg_idx_t      x_rd;
  word_t         x_result;
  logic          x_halt;

  logic     redirect;
  word_t    redirect_pc;
  logic     m_we;
  reg_idx_t m_rd;
  word_t    m_data;

  assign pc = f_pc;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) i_fetch_unit (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (f_pc)
  );

  decode_stage i_decode_stage (
    .clk            (clk),
    .rst            (rst),
    .redirect       (redirect),
    .f_pc           (f_pc),
    .insn_from_imem (insn_from_imem),
    .w_we           (w_we),
    .w_rd           (w_rd),
    .w_data         (w_data),
    .d_pc           (d_pc),
    .d_insn         (d_insn),
    .d_status       (d_status),
    .d_op           (d_op),
    .d_rs1          (d_rs1),
    .d_rs2          (d_rs2),
    .d_rs1_data     (d_rs1_data),
    .d_rs2_data     (d_rs2_data),
    .d_rd           (d_rd),
    .d_we           (d_we),
    .d_imm          (d_imm),
    .d_halt         (d_halt)
  );

  execute_stage i_execute_stage (
    .clk         (clk),
    .rst         (rst),
    .d_pc        (d_pc),
    .d_insn      (d_insn),
    .d_status    (d_status),
    .d_op        (d_op),
    .d_rs1       (d_rs1),
    .d_rs2       (d_rs2),
    .d_rs1_data  (d_rs1_data),
    .d_rs2_data  (d_rs2_data),
    .d_rd        (d_rd),
    .d_we        (d_we),
    .d_imm       (d_imm),
    .d_halt      (d_halt),
    .m_we        (m_we),
    .m_rd        (m_rd),
    .m_data      (m_data),
    .w_we        (w_we),
    .w_rd        (w_rd),
    .w_data      (w_data),
    .x_pc        (x_pc),
    .x_insn      (x_insn),
    .x_status    (x_status),
    .x_we        (x_we),
    .x_rd        (x_rd),
    .x_result    (x_result),
    .x_halt      (x_halt),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  retire_stage i_retire_stage (
    .clk          (clk),
    .rst          (rst),
    .x_pc         (x_pc),
    .x_insn       (x_insn),
    .x_status     (x_status),
    .x_we         (x_we),
    .x_rd         (x_rd),
    .x_result     (x_result),
    .x_halt       (x_halt),
    .m_we         (m_we),
    .m_rd         (m_rd),
    .m_data       (m_data),
    .w_we         (w_we),
    .w_rd         (w_rd),
    .w_data       (w_data),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .halt         (halt)
  );

endmodule

// File: hw/rv_pkg.sv
package rv_pkg;

  // architectural widths
  typedef logic [31:0] word_t;
  typedef logic [31:0] insn_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  // major opcodes of the supported subset
  localparam opcode_t OPC_LUI     = 7'b01_101_11;
  localparam opcode_t OPC_JAL     = 7'b11_011_11;
  localparam opcode_t OPC_JALR    = 7'b11_001_11;
  localparam opcode_t OPC_BRANCH  = 7'b11_000_11;
  localparam opcode_t OPC_REG_IMM = 7'b00_100_11;
  localparam opcode_t OPC_REG_REG = 7'b01_100_11;
  localparam opcode_t OPC_SYSTEM  = 7'b11_100_11;

  // one member per supported instruction
  typedef enum logic [5:0] {
    OP_NOP,
    OP_LUI,
    OP_ADDI,
    OP_SLTI,
    OP_SLTIU,
    OP_XORI,
    OP_ORI,
    OP_ANDI,
    OP_SLLI,
    OP_SRLI,
    OP_SRAI,
    OP_ADD,
    OP_SUB,
    OP_SLL,
    OP_SLT,
    OP_SLTU,
    OP_XOR,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    OP_BEQ,
    OP_BNE,
    OP_BLT,
    OP_BGE,
    OP_BLTU,
    OP_BGEU,
    OP_JAL,
    OP_JALR,
    OP_ECALL
  } op_e;

  // what occupies a stage in a given cycle
  typedef enum logic [2:0] {
    CYCLE_INVALID      = 3'd0,
    CYCLE_RESET        = 3'd1,
    CYCLE_NO_STALL     = 3'd2,
    CYCLE_TAKEN_BRANCH = 3'd4
  } cycle_status_e;

endpackage

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_pkg::*;
();

  localparam word_t RESET_PC = 32'h0;
  localparam int IMEM_WORDS = 128;
  localparam insn_t NOP_INSN = 32'h0000_0013;
  localparam int MODEL_STEP_LIMIT = 512;
  // seven programs, each well under 100 cycles from reset to halt, with wide margin
  localparam int TIMEOUT_CYCLES = 3000;

  localparam logic [0:5][2:0] RI_F3 = {3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
  // {funct7, funct3} of add sub sll slt sltu xor srl sra or and
  localparam logic [0:9][9:0] RR_OPS = {10'h000, 10'h100, 10'h001, 10'h002, 10'h003,
                                        10'h004, 10'h005, 10'h105, 10'h006, 10'h007};

  typedef struct packed {
    word_t         pc;
    insn_t         insn;
    cycle_status_e status;
    logic          we;
    reg_idx_t      rd;
    word_t         data;
    logic          halt;
  } trace_entry_t;

  logic          clk;
  logic          rst;
  word_t         pc;
  insn_t         insn_from_imem;
  logic          w_we;
  reg_idx_t      w_rd;
  word_t         w_data;
  word_t         trace_pc;
  insn_t         trace_insn;
  cycle_status_e trace_status;
  logic          halt;

  insn_t        imem [IMEM_WORDS];
  word_t        imem_index;
  int           prog_len;
  int           model_flushes;
  int           cycle_count = 0;
  trace_entry_t expected_q [$];

  rv_core #(
    .RESET_PC (RESET_PC)
  ) i_dut (
    .clk            (clk),
    .rst            (rst),
    .pc             (pc),
    .insn_from_imem (insn_from_imem),
    .w_we           (w_we),
    .w_rd           (w_rd),
    .w_data         (w_data),
    .trace_pc       (trace_pc),
    .trace_insn     (trace_insn),
    .trace_status   (trace_status),
    .halt           (halt)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // instruction memory answers in the same cycle
  assign imem_index = (pc - RESET_PC) >> 2;
  assign insn_from_imem = (imem_index < IMEM_WORDS) ? imem[imem_index] : NOP_INSN;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("Timeout: the core did not finish within %0d cycles", cycle_count));
    end
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string msg);
    abort_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
  endtask

  function automatic insn_t r_type(input logic [6:0] f7, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3,
                                   input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic insn_t i_type(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd,
                                   input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic insn_t b_type(input logic [12:0] off, input reg_idx_t rs2,
                                   input reg_idx_t rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic insn_t j_type(input logic [20:0] off, input reg_idx_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
  endfunction

  function automatic insn_t u_type(input logic [19:0] upper, input reg_idx_t rd);
    return {upper, rd, 7'h37};
  endfunction

  function automatic logic [11:0] random_imm();
    word_t r;
    r = $urandom();
    return r[11:0];
  endfunction

  // reset goes high first, the memory is filled away from the clock edge
  task automatic begin_program();
    @(posedge clk);
    rst <= 1'b1;
    @(negedge clk);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = NOP_INSN;
    end
    prog_len = 0;
  endtask

  task automatic put_insn(input insn_t insn);
    assert (prog_len < IMEM_WORDS) else abort_run("program does not fit in the memory");
    imem[prog_len] = insn;
    prog_len++;
  endtask

  // lui plus addi, upper part rounded for the sign of the low 12 bits
  task automatic load_const(input reg_idx_t rd, input word_t value);
    word_t upper;
    upper = value + 32'h800;
    put_insn(u_type(upper[31:12], rd));
    put_insn(i_type(value[11:0], rd, 3'd0, rd, 7'h13));
  endtask

  // architectural run of the program, one trace entry per writeback cycle
  task automatic run_model();
    word_t        regs [32];
    word_t        mpc;
    word_t        a;
    word_t        b;
    word_t        imm;
    word_t        val;
    word_t        next_pc;
    word_t        idx;
    insn_t        insn;
    reg_idx_t     rd;
    logic [2:0]   f3;
    logic [6:0]   f7;
    logic         wr;
    logic         taken;
    logic         stop;
    int           steps;
    trace_entry_t e;
    expected_q.delete();
    model_flushes = 0;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    mpc = RESET_PC;
    stop = 1'b0;
    steps = 0;
    while (!stop) begin
      idx = (mpc - RESET_PC) >> 2;
      insn = (idx < IMEM_WORDS) ? imem[idx] : NOP_INSN;
      rd = insn[11:7];
      f3 = insn[14:12];
      f7 = insn[31:25];
      a = regs[insn[19:15]];
      b = regs[insn[24:20]];
      imm = {{20{insn[31]}}, insn[31:20]};
      wr = 1'b0;
      val = '0;
      taken = 1'b0;
      next_pc = mpc + 32'd4;
      case (insn[6:0])
        7'h37: begin
          wr = 1'b1;
          val = {insn[31:12], 12'h000};
        end
        7'h13: begin
          wr = 1'b1;
          case (f3)
            3'd0: val = a + imm;
            3'd2: val = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            3'd3: val = (a < imm) ? 32'd1 : 32'd0;
            3'd4: val = a ^ imm;
            3'd6: val = a | imm;
            3'd7: val = a & imm;
            3'd1: begin
              if (f7 == 7'h00) val = a << insn[24:20];
              else wr = 1'b0;
            end
            default: begin
              if (f7 == 7'h00) val = a >> insn[24:20];
              else if (f7 == 7'h20) val = $signed(a) >>> insn[24:20];
              else wr = 1'b0;
            end
          endcase
        end
        7'h33: begin
          wr = 1'b1;
          case ({f7, f3})
            10'h000: val = a + b;
            10'h100: val = a - b;
            10'h001: val = a << b[4:0];
            10'h002: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            10'h003: val = (a < b) ? 32'd1 : 32'd0;
            10'h004: val = a ^ b;
            10'h005: val = a >> b[4:0];
            10'h105: val = $signed(a) >>> b[4:0];
            10'h006: val = a | b;
            10'h007: val = a & b;
            default: wr = 1'b0;
          endcase
        end
        7'h63: begin
          case (f3)
            3'd0: taken = a == b;
            3'd1: taken = a != b;
            3'd4: taken = $signed(a) < $signed(b);
            3'd5: taken = $signed(a) >= $signed(b);
            3'd6: taken = a < b;
            3'd7: taken = a >= b;
            default: taken = 1'b0;
          endcase
          if (taken) begin
            next_pc = mpc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
          end
        end
        7'h6f: begin
          wr = 1'b1;
          val = mpc + 32'd4;
          taken = 1'b1;
          next_pc = mpc + {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
        end
        7'h67: begin
          if (f3 == 3'd0) begin
            wr = 1'b1;
            val = mpc + 32'd4;
            taken = 1'b1;
            next_pc = (a + imm) & ~32'd1;
          end
        end
        7'h73: stop = (insn == 32'h0000_0073);
        default: wr = 1'b0;
      endcase
      e.pc = mpc;
      e.insn = insn;
      e.status = CYCLE_NO_STALL;
      e.we = wr && rd != 5'd0;
      e.rd = rd;
      e.data = val;
      e.halt = stop;
      expected_q.push_back(e);
      if (e.we) regs[rd] = val;
      if (taken) begin
        e.status = CYCLE_TAKEN_BRANCH;
        e.we = 1'b0;
        expected_q.push_back(e);
        expected_q.push_back(e);
        model_flushes += 2;
      end
      mpc = next_pc;
      steps++;
      assert (steps < MODEL_STEP_LIMIT) else abort_run("reference model never reached an ecall");
    end
  endtask

  task automatic expect_reset_bubble();
    assert (trace_status == CYCLE_RESET)
      else report_mismatch($sformatf("status %s in reset, expected CYCLE_RESET",
                                     trace_status.name()));
    assert (halt == 1'b0) else report_mismatch("halt high in reset");
    assert (w_we == 1'b0) else report_mismatch("commit seen in reset");
  endtask

  task automatic compare_trace(input trace_entry_t e);
    assert (trace_status == e.status)
      else report_mismatch($sformatf("status %s, expected %s (pc %h)",
                                     trace_status.name(), e.status.name(), e.pc));
    if (e.status == CYCLE_NO_STALL) begin
      assert (trace_pc == e.pc)
        else report_mismatch($sformatf("trace_pc %h, expected %h", trace_pc, e.pc));
      assert (trace_insn == e.insn)
        else report_mismatch($sformatf("trace_insn %h at pc %h, expected %h",
                                       trace_insn, e.pc, e.insn));
    end
    assert (halt == e.halt)
      else report_mismatch($sformatf("halt %b at pc %h, expected %b", halt, e.pc, e.halt));
    assert (w_we == e.we)
      else report_mismatch($sformatf("w_we %b at pc %h, expected %b", w_we, e.pc, e.we));
    if (e.we) begin
      assert (w_rd == e.rd)
        else report_mismatch($sformatf("w_rd %0d at pc %h, expected %0d", w_rd, e.pc, e.rd));
      assert (w_data == e.data)
        else report_mismatch($sformatf("x%0d data %h at pc %h, expected %h",
                                       e.rd, w_data, e.pc, e.data));
    end
  endtask

  // 4 cycles of reset, 4 bubble cycles, then one trace entry per cycle up to the ecall
  task automatic run_program();
    trace_entry_t e;
    run_model();
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      expect_reset_bubble();
      assert (pc == RESET_PC)
        else report_mismatch($sformatf("pc %h in reset, expected %h", pc, RESET_PC));
    end
    @(posedge clk);
    rst <= 1'b0;
    repeat (4) begin
      @(negedge clk);
      expect_reset_bubble();
    end
    while (expected_q.size() > 0) begin
      e = expected_q.pop_front();
      @(negedge clk);
      compare_trace(e);
    end
  endtask

  task automatic reset_sequence();
    begin_program();
    put_insn(i_type(12'd1, 5'd0, 3'd0, 5'd1, 7'h13));
    put_insn(i_type(12'd2, 5'd1, 3'd0, 5'd2, 7'h13));
    put_insn(32'h0000_0073);
    run_program();
  endtask

  task automatic alu_operations();
    word_t    sh;
    reg_idx_t rd;
    for (int round = 0; round < 2; round++) begin
      begin_program();
      load_const(5'd1, $urandom());
      load_const(5'd2, $urandom());
      rd = 5'd3;
      for (int k = 0; k < 6; k++) begin
        put_insn(i_type(random_imm(), 5'd1, RI_F3[k], rd, 7'h13));
        rd = rd + 5'd1;
      end
      sh = $urandom();
      put_insn(i_type({7'h00, sh[4:0]}, 5'd1, 3'd1, 5'd9, 7'h13));
      put_insn(i_type({7'h00, sh[9:5]}, 5'd1, 3'd5, 5'd10, 7'h13));
      put_insn(i_type({7'h20, sh[14:10]}, 5'd1, 3'd5, 5'd11, 7'h13));
      rd = 5'd12;
      for (int k = 0; k < 10; k++) begin
        put_insn(r_type(RR_OPS[k][9:3], 5'd2, 5'd1, RR_OPS[k][2:0], rd));
        rd = rd + 5'd1;
      end
      // chain on earlier results
      put_insn(i_type(random_imm(), 5'd3, 3'd0, 5'd22, 7'h13));
      put_insn(r_type(7'h20, 5'd22, 5'd19, 3'd0, 5'd23));
      put_insn(32'h0000_0073);
      run_program();
    end
  endtask

  task automatic bypass_distances();
    begin_program();
    for (int d = 1; d <= 3; d++) begin
      put_insn(i_type(random_imm(), 5'd0, 3'd0, 5'd5, 7'h13));
      // fillers write x0 and must never commit
      for (int k = 1; k < d; k++) begin
        put_insn(i_type(random_imm(), 5'd5, 3'd0, 5'd0, 7'h13));
      end
      put_insn(r_type(7'h00, 5'd5, 5'd5, 3'd0, 5'd6));
      put_insn(r_type(7'h20, 5'd5, 5'd6, 3'd0, 5'd7));
    end
    // same register in memory and writeback, memory must win
    put_insn(i_type(random_imm(), 5'd0, 3'd0, 5'd8, 7'h13));
    put_insn(i_type(random_imm(), 5'd8, 3'd0, 5'd8, 7'h13));
    put_insn(r_type(7'h00, 5'd0, 5'd8, 3'd0, 5'd9));
    // x0 written just before it is read
    put_insn(i_type(12'd77, 5'd8, 3'd0, 5'd0, 7'h13));
    put_insn(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd10));
    put_insn(r_type(7'h00, 5'd8, 5'd0, 3'd6, 5'd11));
    put_insn(32'h0000_0073);
    run_program();
  endtask

  task automatic branch_block(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2);
    // target is the next block, so a taken branch skips both counters
    put_insn(b_type(13'd12, rs2, rs1, f3));
    put_insn(i_type(12'd1, 5'd10, 3'd0, 5'd10, 7'h13));
    put_insn(i_type(12'd1, 5'd11, 3'd0, 5'd11, 7'h13));
  endtask

  task automatic branch_outcomes();
    word_t neg;
    word_t pos;
    neg = $urandom() | 32'h8000_0000;
    pos = $urandom() & 32'h7fff_ffff;
    begin_program();
    // x1 and x3 equal and negative, x2 positive
    load_const(5'd1, neg);
    load_const(5'd2, pos);
    load_const(5'd3, neg);
    branch_block(3'd0, 5'd1, 5'd3);
    branch_block(3'd0, 5'd1, 5'd2);
    branch_block(3'd1, 5'd1, 5'd2);
    branch_block(3'd1, 5'd1, 5'd3);
    branch_block(3'd4, 5'd1, 5'd2);
    branch_block(3'd4, 5'd2, 5'd1);
    branch_block(3'd5, 5'd2, 5'd1);
    branch_block(3'd5, 5'd1, 5'd2);
    branch_block(3'd6, 5'd2, 5'd1);
    branch_block(3'd6, 5'd1, 5'd2);
    branch_block(3'd7, 5'd1, 5'd2);
    branch_block(3'd7, 5'd2, 5'd1);
    put_insn(32'h0000_0073);
    run_model();
    assert (model_flushes == 12) else abort_run("branch program does not take six branches");
    run_program();
  endtask

  task automatic jump_links();
    begin_program();
    put_insn(j_type(21'd12, 5'd1));
    put_insn(i_type(12'd1, 5'd0, 3'd0, 5'd10, 7'h13));
    put_insn(i_type(12'd1, 5'd0, 3'd0, 5'd11, 7'h13));
    put_insn(r_type(7'h00, 5'd0, 5'd1, 3'd0, 5'd2));
    // word 8 plus one, bit 0 must be dropped
    put_insn(i_type(12'd33, 5'd0, 3'd0, 5'd6, 7'h13));
    put_insn(i_type(12'd0, 5'd6, 3'd0, 5'd7, 7'h67));
    put_insn(i_type(12'd1, 5'd0, 3'd0, 5'd12, 7'h13));
    put_insn(i_type(12'd1, 5'd0, 3'd0, 5'd13, 7'h13));
    put_insn(i_type(12'd0, 5'd7, 3'd0, 5'd8, 7'h13));
    // word 12 through a negative offset
    put_insn(i_type(12'd57, 5'd0, 3'd0, 5'd6, 7'h13));
    put_insn(i_type(12'hff7, 5'd6, 3'd0, 5'd9, 7'h67));
    put_insn(i_type(12'd1, 5'd0, 3'd0, 5'd14, 7'h13));
    put_insn(j_type(21'd8, 5'd0));
    put_insn(i_type(12'd1, 5'd0, 3'd0, 5'd15, 7'h13));
    put_insn(32'h0000_0073);
    run_program();
  endtask

  task automatic ecall_halt();
    begin_program();
    put_insn(i_type(12'd7, 5'd0, 3'd0, 5'd1, 7'h13));
    put_insn(i_type(12'd1, 5'd1, 3'd0, 5'd2, 7'h13));
    put_insn(32'h0000_0073);
    put_insn(i_type(12'd9, 5'd0, 3'd0, 5'd3, 7'h13));
    put_insn(i_type(12'd9, 5'd0, 3'd0, 5'd4, 7'h13));
    run_program();
  endtask

  initial begin
    rst = 1'b1;
    prog_len = 0;
    model_flushes = 0;
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = NOP_INSN;
    end
    void'($urandom(32'hd3b5ee30));
    reset_sequence();
    alu_operations();
    bypass_distances();
    branch_outcomes();
    jump_links();
    ecall_halt();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: verilog.f
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/alu.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/retire_stage.sv
hw/rv_core.sv
sim/tb_rv_core.sv
